// ==== sources.f ====
verilog/adder_cfg_pkg.sv
verilog/adder_types_pkg.sv
verilog/operand_stage.sv
verilog/lookahead_group.sv
verilog/carry_network.sv
verilog/sum_stage.sv
verilog/cla_adder_top.sv
sim/tb_clock_gen.sv
sim/cla_adder_tb.sv

// ==== Makefile ====
# Verilator build for the carry-lookahead adder
TOP := cla_adder_tb
LOG := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --top-module cla_adder_top -f sources.f

sim:
	verilator --binary --timing -j 0 --top-module $(TOP) -Mdir obj_dir -f sources.f
	./obj_dir/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "^TB PASSED$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// ==== sim/cla_adder_tb.sv ====
/*
  Directed testbench for the registered carry-lookahead adder.
  Operand pairs are driven just after a rising edge and their expected
  {carry, sum} is queued; each result is checked two edges later.
*/

`timescale 1ns/10ps

module cla_adder_tb;

    import adder_cfg_pkg::*;

    localparam int CLK_PERIOD   = 10;
    localparam int RESET_CYCLES = 16;
    localparam int DRIVE_DELAY  = 1;
    localparam int NUM_RANDOM   = 200;
    localparam int NUM_STREAM   = 32;

    // cycle budget of each test, summed for the watchdog
    localparam int RESET_TEST_CYCLES = 2;
    localparam int CORNER_CYCLES     = 7 * 3;
    localparam int BOUNDARY_CYCLES   = 2 * NUM_GROUPS * 3;
    localparam int RANDOM_CYCLES     = NUM_RANDOM * 3;
    localparam int STREAM_CYCLES     = NUM_STREAM + 2;
    localparam int TIMEOUT_CYCLES    = RESET_CYCLES + RESET_TEST_CYCLES + CORNER_CYCLES
                                     + BOUNDARY_CYCLES + RANDOM_CYCLES + STREAM_CYCLES + 100;

    typedef struct packed {
        logic                valid;  // idle slots are not checked
        logic [DATA_WIDTH:0] value;  // {carry, sum}
    } expect_t;

    logic                  clk;
    logic                  reset;
    logic [DATA_WIDTH-1:0] a_i;
    logic [DATA_WIDTH-1:0] b_i;
    logic                  carry_i;
    logic [DATA_WIDTH-1:0] sum_o;
    logic                  carry_o;

    expect_t expect_q[$];
    string   test_name;
    int      check_count = 0;
    int      fail_count  = 0;
    int      test_checks = 0;
    int      test_fails  = 0;
    integer  seed        = 56;

    tb_clock_gen #(.PERIOD(CLK_PERIOD), .RESET_CYCLES(RESET_CYCLES)) u_clock_gen (
        .clk_o  (clk),
        .reset_o(reset)
    );

    cla_adder_top uut (
        .clk_i  (clk),
        .reset_i(reset),
        .a_i    (a_i),
        .b_i    (b_i),
        .carry_i(carry_i),
        .sum_o  (sum_o),
        .carry_o(carry_o)
    );

    // plain binary addition, carry lands in the top bit
    function automatic logic [DATA_WIDTH:0] ref_add(input logic [DATA_WIDTH-1:0] a,
                                                    input logic [DATA_WIDTH-1:0] b,
                                                    input logic                  cin);
        return {1'b0, a} + {1'b0, b} + {{DATA_WIDTH{1'b0}}, cin};
    endfunction

    task automatic check_value(input string name, input logic [DATA_WIDTH:0] expected,
                               input logic [DATA_WIDTH:0] actual);
        check_count++;
        test_checks++;
        if (actual !== expected) begin
            fail_count++;
            test_fails++;
            $display("[ERROR] %s: expected %h, actual %h at %0t", name, expected, actual,
                     $time);
        end
    endtask

    task automatic begin_test(input string name);
        test_name   = name;
        test_checks = 0;
        test_fails  = 0;
    endtask

    task automatic end_test();
        $display("test %s done: %0d checks, %0d mismatches", test_name, test_checks,
                 test_fails);
    endtask

    task automatic next_edge();
        @(posedge clk);
        #DRIVE_DELAY;  // outputs settled, inputs may change
    endtask

    // front entry has seen two edges once a second entry is queued
    task automatic advance(input expect_t exp);
        expect_t due;
        expect_q.push_back(exp);
        next_edge();
        if (expect_q.size() > 1) begin
            due = expect_q.pop_front();
            if (due.valid) begin
                check_value(test_name, due.value, {carry_o, sum_o});
            end
        end
    endtask

    task automatic apply_pair(input logic [DATA_WIDTH-1:0] a, input logic [DATA_WIDTH-1:0] b,
                              input logic cin);
        expect_t exp;
        a_i       = a;
        b_i       = b;
        carry_i   = cin;
        exp.valid = 1'b1;
        exp.value = ref_add(a, b, cin);
        advance(exp);
    endtask

    task automatic apply_idle();
        expect_t exp;
        exp     = '0;
        a_i     = '0;
        b_i     = '0;
        carry_i = 1'b0;
        advance(exp);
    endtask

    task automatic apply_isolated(input logic [DATA_WIDTH-1:0] a,
                                  input logic [DATA_WIDTH-1:0] b, input logic cin);
        apply_pair(a, b, cin);
        apply_idle();
        apply_idle();
    endtask

    task automatic test_reset_state();
        begin_test("reset_state");
        a_i     = 16'h1234;  // nonzero pair must not leak through reset
        b_i     = 16'h4321;
        carry_i = 1'b1;
        repeat (RESET_CYCLES) begin
            next_edge();
            check_value(test_name, '0, {carry_o, sum_o});
        end
        next_edge();
        check_value(test_name, '0, {carry_o, sum_o});  // operand reg was still clear
        next_edge();
        check_value(test_name, ref_add(16'h1234, 16'h4321, 1'b1), {carry_o, sum_o});
        end_test();
    endtask

    task automatic test_corner_operands();
        begin_test("corner_operands");
        apply_isolated(16'h0000, 16'h0000, 1'b0);
        apply_isolated(16'hFFFF, 16'h0000, 1'b1);  // carry ripples through every group
        apply_isolated(16'hFFFF, 16'hFFFF, 1'b1);
        apply_isolated(16'hAAAA, 16'h5555, 1'b0);
        apply_isolated(16'h5555, 16'hAAAA, 1'b1);
        apply_isolated(16'hAAAA, 16'hAAAA, 1'b0);
        apply_isolated(16'h5555, 16'h5555, 1'b1);
        end_test();
    endtask

    // group k generates, every higher group only propagates
    task automatic test_group_boundary();
        logic [DATA_WIDTH-1:0] ones;
        logic [DATA_WIDTH-1:0] upper;
        logic [DATA_WIDTH-1:0] grp;
        logic [DATA_WIDTH-1:0] low;
        logic [DATA_WIDTH-1:0] top;
        begin_test("group_boundary");
        ones = '1;
        for (int k = 0; k < NUM_GROUPS; k++) begin
            upper = ones << (GROUP_SIZE * (k + 1));
            grp   = {{(DATA_WIDTH - GROUP_SIZE){1'b0}}, {GROUP_SIZE{1'b1}}} << (GROUP_SIZE * k);
            low   = {{(DATA_WIDTH - 1){1'b0}}, 1'b1} << (GROUP_SIZE * k);
            top   = low << (GROUP_SIZE - 1);
            apply_isolated(upper | top, top, 1'b0);  // top bit of group generates
            apply_isolated(upper | grp, low, 1'b0);  // bottom bit generates, rest pass
        end
        end_test();
    endtask

    task automatic test_random_operands();
        logic [31:0] rnd_a;
        logic [31:0] rnd_b;
        logic [31:0] rnd_c;
        begin_test("random_operands");
        for (int i = 0; i < NUM_RANDOM; i++) begin
            rnd_a = $random(seed);
            rnd_b = $random(seed);
            rnd_c = $random(seed);
            apply_isolated(rnd_a[DATA_WIDTH-1:0], rnd_b[DATA_WIDTH-1:0], rnd_c[0]);
        end
        end_test();
    endtask

    // one pair per clock, two pairs in flight
    task automatic test_back_to_back();
        logic [31:0] rnd_a;
        logic [31:0] rnd_b;
        begin_test("back_to_back");
        for (int i = 0; i < NUM_STREAM; i++) begin
            rnd_a = $random(seed);
            rnd_b = $random(seed);
            apply_pair(rnd_a[DATA_WIDTH-1:0], rnd_b[DATA_WIDTH-1:0], rnd_a[31]);
        end
        apply_idle();
        apply_idle();
        end_test();
    endtask

    initial begin
        a_i     = '0;
        b_i     = '0;
        carry_i = 1'b0;
        test_reset_state();
        test_corner_operands();
        test_group_boundary();
        test_random_operands();
        test_back_to_back();
        $display("checks: %0d passed, %0d failed", check_count - fail_count, fail_count);
        if (fail_count == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

    initial begin
        #(TIMEOUT_CYCLES * CLK_PERIOD);
        $display("watchdog expired after %0d cycles, the tests did not finish",
                 TIMEOUT_CYCLES);
        $display("TB FAILED");
        $finish;
    end

endmodule

// ==== sim/tb_clock_gen.sv ====
/*
  Clock and reset source for the adder testbench.
  Free-running clock; reset is held high for a fixed number of rising
  edges and released shortly after the last of them.
*/

`timescale 1ns/10ps

module tb_clock_gen #(
    parameter int PERIOD       = 10,
    parameter int RESET_CYCLES = 16
) (
    output logic clk_o,
    output logic reset_o
);

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD / 2) clk_o = ~clk_o;
    end

    initial begin
        reset_o = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk_o);
        #1 reset_o = 1'b0;  // released with the same skew as other inputs
    end

endmodule

// ==== verilog/cla_adder_top.sv ====
/*
  Registered 16-bit carry-lookahead adder, sum_o = a_i + b_i + carry_i.
  A new pair may be applied every clock; the result appears one edge
  after the operands are captured, with no stall and no handshake.
*/

`timescale 1ns/10ps

module cla_adder_top (
    input  logic                               clk_i,
    input  logic                               reset_i,
    input  logic [adder_cfg_pkg::DATA_WIDTH-1:0] a_i,
    input  logic [adder_cfg_pkg::DATA_WIDTH-1:0] b_i,
    input  logic                               carry_i,
    output logic [adder_cfg_pkg::DATA_WIDTH-1:0] sum_o,
    output logic                               carry_o
);

    import adder_types_pkg::*;

    operand_t operand;
    pg_t      pg;
    carry_t   carry;
    result_t  result;

    assign operand.a        = a_i;
    assign operand.b        = b_i;
    assign operand.carry_in = carry_i;

    operand_stage u_operand_stage (
        .clk_i    (clk_i),
        .reset_i  (reset_i),
        .operand_i(operand),
        .pg_o     (pg)
    );

    carry_network u_carry_network (
        .pg_i   (pg),
        .carry_o(carry)
    );

    sum_stage u_sum_stage (
        .clk_i   (clk_i),
        .reset_i (reset_i),
        .pg_i    (pg),
        .carry_i (carry),
        .result_o(result)
    );

    assign sum_o   = result.sum;
    assign carry_o = result.carry_out;

endmodule

// ==== verilog/sum_stage.sv ====
/*
  Output side of the adder. Each sum bit is the propagate bit xor the
  carry into that bit; sum and carry-out are captured together in the
  result register one edge after the operand register.
*/

`timescale 1ns/10ps

module sum_stage (
    input  logic                     clk_i,
    input  logic                     reset_i,
    input  adder_types_pkg::pg_t     pg_i,
    input  adder_types_pkg::carry_t  carry_i,
    output adder_types_pkg::result_t result_o
);

    import adder_cfg_pkg::*;
    import adder_types_pkg::*;

    logic [DATA_WIDTH-1:0] sum;
    result_t               result_d;

    assign sum = pg_i.p ^ carry_i.c;  // g plays no part in the sum itself

    always_comb begin
        result_d.sum       = sum;
        result_d.carry_out = carry_i.carry_out;
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            result_o <= '0;
        end else begin
            result_o <= result_d;  // loads every cycle, two pairs in flight
        end
    end

endmodule

// ==== verilog/carry_network.sv ====
/*
  Two-level carry-lookahead network, purely combinational.
  One lookahead_group per 4-bit slice forms the in-slice carries; the
  second level derives each slice carry-in and the adder carry-out
  directly from the group terms, so no carry ripples between slices.
*/

`timescale 1ns/10ps

module carry_network (
    input  adder_types_pkg::pg_t    pg_i,
    output adder_types_pkg::carry_t carry_o
);

    import adder_cfg_pkg::*;

    logic [NUM_GROUPS-1:0] group_g;    // per-slice generate
    logic [NUM_GROUPS-1:0] group_p;    // per-slice propagate
    logic [NUM_GROUPS-1:0] group_cin;  // carry into each slice
    logic [DATA_WIDTH-1:0] bit_carry;  // bit_carry[k] is the carry into bit k+1
    logic                  carry_out;

    for (genvar gi = 0; gi < NUM_GROUPS; gi++) begin : g_group
        lookahead_group u_group (
            .g_i      (pg_i.g[gi*GROUP_SIZE +: GROUP_SIZE]),
            .p_i      (pg_i.p[gi*GROUP_SIZE +: GROUP_SIZE]),
            .carry_i  (group_cin[gi]),
            .carry_o  (bit_carry[gi*GROUP_SIZE +: GROUP_SIZE]),
            .group_g_o(group_g[gi]),
            .group_p_o(group_p[gi])
        );
    end

    // second level, same sum-of-products shape as inside a slice
    assign group_cin[0] = pg_i.carry_in;

    assign group_cin[1] = group_g[0]
                        | (group_p[0] & pg_i.carry_in);

    assign group_cin[2] = group_g[1]
                        | (group_p[1] & group_g[0])
                        | (group_p[1] & group_p[0] & pg_i.carry_in);

    assign group_cin[3] = group_g[2]
                        | (group_p[2] & group_g[1])
                        | (group_p[2] & group_p[1] & group_g[0])
                        | (group_p[2] & group_p[1] & group_p[0] & pg_i.carry_in);

    // fast carry-out straight from the group terms
    assign carry_out = group_g[3]
                     | (group_p[3] & group_g[2])
                     | (group_p[3] & group_p[2] & group_g[1])
                     | (group_p[3] & group_p[2] & group_p[1] & group_g[0])
                     | (group_p[3] & group_p[2] & group_p[1] & group_p[0] & pg_i.carry_in);

    // bit 0 takes the adder carry-in, the rest come from the slices
    assign carry_o.c         = {bit_carry[DATA_WIDTH-2:0], pg_i.carry_in};
    assign carry_o.carry_out = carry_out;

endmodule

// ==== verilog/lookahead_group.sv ====
/*
  First-level lookahead cell for one 4-bit slice.
  Every carry is a flat sum of products of g, p and the slice carry-in.
  Group generate and propagate feed the second-level lookahead.
*/

`timescale 1ns/10ps

module lookahead_group (
    input  logic [adder_cfg_pkg::GROUP_SIZE-1:0] g_i,
    input  logic [adder_cfg_pkg::GROUP_SIZE-1:0] p_i,
    input  logic                                 carry_i,
    output logic [adder_cfg_pkg::GROUP_SIZE-1:0] carry_o,  // carries into bits 1..4
    output logic                                 group_g_o,
    output logic                                 group_p_o
);

    // carry into bit 1
    assign carry_o[0] = g_i[0]
                      | (p_i[0] & carry_i);

    // carry into bit 2
    assign carry_o[1] = g_i[1]
                      | (p_i[1] & g_i[0])
                      | (p_i[1] & p_i[0] & carry_i);

    // carry into bit 3
    assign carry_o[2] = g_i[2]
                      | (p_i[2] & g_i[1])
                      | (p_i[2] & p_i[1] & g_i[0])
                      | (p_i[2] & p_i[1] & p_i[0] & carry_i);

    // carry out of the slice
    assign carry_o[3] = g_i[3]
                      | (p_i[3] & g_i[2])
                      | (p_i[3] & p_i[2] & g_i[1])
                      | (p_i[3] & p_i[2] & p_i[1] & g_i[0])
                      | (p_i[3] & p_i[2] & p_i[1] & p_i[0] & carry_i);

    // slice produces a carry by itself
    assign group_g_o = g_i[3]
                     | (p_i[3] & g_i[2])
                     | (p_i[3] & p_i[2] & g_i[1])
                     | (p_i[3] & p_i[2] & p_i[1] & g_i[0]);

    assign group_p_o = &p_i;  // slice passes an incoming carry through

endmodule

// ==== verilog/operand_stage.sv ====
/*
  Input side of the adder. Captures both operands and the carry-in on
  every rising edge and derives per-bit generate and propagate from the
  registered pair. The pg_o output is combinational from the register.
*/

`timescale 1ns/10ps

module operand_stage (
    input  logic                      clk_i,
    input  logic                      reset_i,
    input  adder_types_pkg::operand_t operand_i,
    output adder_types_pkg::pg_t      pg_o
);

    import adder_types_pkg::*;

    operand_t operand_q;  // registered operand pair

    // a new pair is accepted on every clock, no enable
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            operand_q <= '0;
        end else begin
            operand_q <= operand_i;
        end
    end

    // a zero register yields g = p = 0, so the result also reads zero
    always_comb begin
        pg_o.g        = operand_q.a & operand_q.b;  // both ones, carry born here
        pg_o.p        = operand_q.a ^ operand_q.b;  // exactly one, carry passes
        pg_o.carry_in = operand_q.carry_in;
    end

endmodule

// ==== verilog/adder_types_pkg.sv ====
/*
  Packed structs that carry data between the adder stages.
  Operands enter as operand_t, leave the input register as pg_t,
  the carry network returns carry_t and the output register holds result_t.
*/

package adder_types_pkg;

    import adder_cfg_pkg::*;

    typedef struct packed {
        logic [DATA_WIDTH-1:0] a;
        logic [DATA_WIDTH-1:0] b;
        logic                  carry_in;
    } operand_t;

    // carry_in rides along so the carry network sees the same operand pair
    typedef struct packed {
        logic [DATA_WIDTH-1:0] g;         // bitwise generate
        logic [DATA_WIDTH-1:0] p;         // bitwise propagate
        logic                  carry_in;
    } pg_t;

    typedef struct packed {
        logic [DATA_WIDTH-1:0] c;         // carry into bit k, c[0] is carry_in
        logic                  carry_out;
    } carry_t;

    typedef struct packed {
        logic [DATA_WIDTH-1:0] sum;
        logic                  carry_out;
    } result_t;

endpackage

// ==== verilog/adder_cfg_pkg.sv ====
/*
  Size constants for the registered carry-lookahead adder.
  Every RTL module and the types package take their widths from here.
  The width must stay a whole multiple of the group size.
*/

package adder_cfg_pkg;

    // operand and sum width
    localparam int DATA_WIDTH = 16;

    // bits handled by one first-level lookahead cell
    localparam int GROUP_SIZE = 4;

    // first-level cells feeding the second-level lookahead
    localparam int NUM_GROUPS = DATA_WIDTH / GROUP_SIZE;

endpackage
